// File: logic/dupmem_pkg.sv
package dupmem_pkg;

  // ------------------------------------------------------------------------
  // default geometry
  // ------------------------------------------------------------------------
  localparam int DEF_WIDTH      = 32;   // data bits per word.
  localparam int DEF_NUMRDPT    = 2;    // read ports, one replica each.
  localparam int DEF_NUMADDR    = 8192;
  localparam int DEF_NUMVBNK    = 8;    // any count, not only powers of two.
  localparam int DEF_NUMVROW    = (DEF_NUMADDR + DEF_NUMVBNK - 1) / DEF_NUMVBNK;
  localparam int DEF_SRAM_DELAY = 2;    // bank read latency.
  localparam int DEF_FLOPIN     = 0;
  localparam int DEF_FLOPOUT    = 1;

  // ------------------------------------------------------------------------
  // address split
  // ------------------------------------------------------------------------
  // Consecutive addresses rotate over the banks, so a linear sweep
  // touches every bank before it reuses one.
  function automatic int unsigned vbank_of(
    input int unsigned adr,
    input int unsigned nvbnk
  );
    return adr % nvbnk;
  endfunction

  function automatic int unsigned vrow_of(
    input int unsigned adr,
    input int unsigned nvbnk
  );
    return adr / nvbnk;
  endfunction

endpackage

// File: logic/dupmem_req_decode.sv
`timescale 1ns/1ps

module dupmem_req_decode
  import dupmem_pkg::*;
#(
  parameter int WIDTH   = DEF_WIDTH,
  parameter int NUMRDPT = DEF_NUMRDPT,
  parameter int NUMADDR = DEF_NUMADDR,
  parameter int NUMVBNK = DEF_NUMVBNK,
  parameter int NUMVROW = DEF_NUMVROW,
  parameter int FLOPIN  = DEF_FLOPIN
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write,
  input  logic [$clog2(NUMADDR)-1:0] wr_adr,
  input  logic [WIDTH-1:0]           din,
  input  logic [WIDTH-1:0]           bw,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*$clog2(NUMADDR)-1:0] rd_adr,
  output logic [NUMVBNK-1:0]         bank_we,
  output logic [((NUMVROW > 1) ? $clog2(NUMVROW) : 1)-1:0] bank_wrow,
  output logic [WIDTH-1:0]           bank_din,
  output logic [WIDTH-1:0]           bank_bw,
  output logic [NUMRDPT*NUMVBNK-1:0] bank_re,
  output logic [NUMRDPT*((NUMVROW > 1) ? $clog2(NUMVROW) : 1)-1:0] bank_rrow,
  output logic [NUMRDPT-1:0]         req_vld,
  output logic [NUMRDPT*((NUMVBNK > 1) ? $clog2(NUMVBNK) : 1)-1:0] bank_sel
);

  localparam int BITADDR = $clog2(NUMADDR);
  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1;
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  logic                       wr_q;
  logic [BITADDR-1:0]         wr_adr_q;
  logic [NUMRDPT-1:0]         rd_q;
  logic [NUMRDPT*BITADDR-1:0] rd_adr_q;
  logic [BITVBNK-1:0]         wr_bank;

  // --------------------------------------------------------------------------
  // optional input stage
  // --------------------------------------------------------------------------
  if (FLOPIN != 0) begin : g_flopin
    always_ff @(posedge clk) begin
      if (rst) begin
        wr_q <= 1'b0;
        rd_q <= '0;
      end else begin
        wr_q <= write;
        rd_q <= read;
      end
    end

    always_ff @(posedge clk) begin
      wr_adr_q <= wr_adr;
      bank_din <= din;
      bank_bw  <= bw;
      rd_adr_q <= rd_adr;
    end
  end else begin : g_noflop
    assign wr_q     = write;
    assign rd_q     = read;
    assign wr_adr_q = wr_adr;
    assign bank_din = din;
    assign bank_bw  = bw;
    assign rd_adr_q = rd_adr;
  end

  // --------------------------------------------------------------------------
  // write side, shared by every replica
  // --------------------------------------------------------------------------
  assign wr_bank   = BITVBNK'(vbank_of(wr_adr_q, NUMVBNK));
  assign bank_wrow = BITVROW'(vrow_of(wr_adr_q, NUMVBNK));

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_wbank
    assign bank_we[b] = wr_q && (wr_bank == BITVBNK'(b)); // one-hot.
  end

  // --------------------------------------------------------------------------
  // read side, port p drives replica p only
  // --------------------------------------------------------------------------
  for (genvar p = 0; p < NUMRDPT; p++) begin : g_port
    logic [BITADDR-1:0] adr;
    logic [BITVBNK-1:0] bank;

    assign adr  = rd_adr_q[p*BITADDR +: BITADDR];
    assign bank = BITVBNK'(vbank_of(adr, NUMVBNK));

    assign bank_rrow[p*BITVROW +: BITVROW] = BITVROW'(vrow_of(adr, NUMVBNK));
    assign bank_sel[p*BITVBNK +: BITVBNK]  = bank; // follows the read to the mux.

    for (genvar b = 0; b < NUMVBNK; b++) begin : g_rbank
      assign bank_re[p*NUMVBNK + b] = rd_q[p] && (bank == BITVBNK'(b));
    end
  end

  assign req_vld = rd_q;

endmodule

// File: logic/dupmem_replica.sv
`timescale 1ns/1ps

module dupmem_replica
  import dupmem_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int NUMVROW    = DEF_NUMVROW,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY
) (
  input  logic                     clk,
  input  logic [NUMVBNK-1:0]       bank_we,
  input  logic [((NUMVROW > 1) ? $clog2(NUMVROW) : 1)-1:0] bank_wrow,
  input  logic [WIDTH-1:0]         bank_din,
  input  logic [WIDTH-1:0]         bank_bw,
  input  logic [NUMVBNK-1:0]       bank_re,
  input  logic [((NUMVROW > 1) ? $clog2(NUMVROW) : 1)-1:0] bank_rrow,
  output logic [NUMVBNK*WIDTH-1:0] bank_dout
);

  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  // --------------------------------------------------------------------------
  // one SRAM model per virtual bank
  // --------------------------------------------------------------------------
  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    logic [WIDTH-1:0] mem [NUMVROW];
    logic [WIDTH-1:0] rd_word;

    // masked write, untouched bits keep the stored value.
    always_ff @(posedge clk) begin
      if (bank_we[b]) begin
        mem[bank_wrow] <= (mem[bank_wrow] & ~bank_bw) | (bank_din & bank_bw);
      end
    end

    if (SRAM_DELAY > 0) begin : g_pipe
      logic [WIDTH-1:0] rd_pipe [SRAM_DELAY];

      // the row is sampled before the write at the same edge lands.
      always_ff @(posedge clk) begin
        if (bank_re[b]) begin
          rd_pipe[0] <= mem[bank_rrow];
        end
        for (int i = 1; i < SRAM_DELAY; i++) begin
          rd_pipe[i] <= rd_pipe[i-1];
        end
      end

      assign rd_word = rd_pipe[SRAM_DELAY-1];
    end else begin : g_flow
      assign rd_word = bank_re[b] ? mem[bank_rrow] : '0; // flow-through.
    end

    assign bank_dout[b*WIDTH +: WIDTH] = rd_word;
  end

endmodule

// File: logic/dupmem_read_return.sv
`timescale 1ns/1ps

module dupmem_read_return
  import dupmem_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  parameter int FLOPOUT    = DEF_FLOPOUT
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [NUMRDPT-1:0]               req_vld,
  input  logic [NUMRDPT*((NUMVBNK > 1) ? $clog2(NUMVBNK) : 1)-1:0] bank_sel,
  input  logic [NUMRDPT*NUMVBNK*WIDTH-1:0] bank_dout,
  output logic [NUMRDPT-1:0]               rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]         rd_dout
);

  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1;

  logic [NUMRDPT-1:0]         vld_d;
  logic [NUMRDPT*BITVBNK-1:0] sel_d;
  logic [NUMRDPT*WIDTH-1:0]   dout_mux;

  // --------------------------------------------------------------------------
  // match the bank latency
  // --------------------------------------------------------------------------
  if (SRAM_DELAY > 0) begin : g_dly
    logic [NUMRDPT-1:0]         vld_pipe [SRAM_DELAY];
    logic [NUMRDPT*BITVBNK-1:0] sel_pipe [SRAM_DELAY];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < SRAM_DELAY; i++) begin
          vld_pipe[i] <= '0;
        end
      end else begin
        vld_pipe[0] <= req_vld;
        for (int i = 1; i < SRAM_DELAY; i++) begin
          vld_pipe[i] <= vld_pipe[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      sel_pipe[0] <= bank_sel;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        sel_pipe[i] <= sel_pipe[i-1];
      end
    end

    assign vld_d = vld_pipe[SRAM_DELAY-1];
    assign sel_d = sel_pipe[SRAM_DELAY-1];
  end else begin : g_nodly
    assign vld_d = req_vld;
    assign sel_d = bank_sel;
  end

  // port p only ever looks at replica p.
  for (genvar p = 0; p < NUMRDPT; p++) begin : g_mux
    logic [BITVBNK-1:0] sel;

    assign sel = sel_d[p*BITVBNK +: BITVBNK];
    assign dout_mux[p*WIDTH +: WIDTH] = bank_dout[(p*NUMVBNK + int'(sel))*WIDTH +: WIDTH];
  end

  // --------------------------------------------------------------------------
  // optional output stage
  // --------------------------------------------------------------------------
  if (FLOPOUT != 0) begin : g_flopout
    always_ff @(posedge clk) begin
      if (rst) begin
        rd_vld <= '0;
      end else begin
        rd_vld <= vld_d;
      end
    end

    always_ff @(posedge clk) begin
      rd_dout <= dout_mux;
    end
  end else begin : g_noflop
    assign rd_vld  = vld_d;
    assign rd_dout = dout_mux;
  end

endmodule

// File: logic/nr1w_dup_mem.sv
`timescale 1ns/1ps

module nr1w_dup_mem
  import dupmem_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMADDR    = DEF_NUMADDR,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int NUMVROW    = (NUMADDR + NUMVBNK - 1) / NUMVBNK,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  parameter int FLOPIN     = DEF_FLOPIN,
  parameter int FLOPOUT    = DEF_FLOPOUT
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               write,
  input  logic [$clog2(NUMADDR)-1:0]         wr_adr,
  input  logic [WIDTH-1:0]                   din,
  input  logic [WIDTH-1:0]                   bw,
  input  logic [NUMRDPT-1:0]                 read,
  input  logic [NUMRDPT*$clog2(NUMADDR)-1:0] rd_adr,
  output logic [NUMRDPT-1:0]                 rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]           rd_dout
);

  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1;
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  logic [NUMVBNK-1:0]               bank_we;
  logic [BITVROW-1:0]               bank_wrow;
  logic [WIDTH-1:0]                 bank_din;
  logic [WIDTH-1:0]                 bank_bw;
  logic [NUMRDPT*NUMVBNK-1:0]       bank_re;
  logic [NUMRDPT*BITVROW-1:0]       bank_rrow;
  logic [NUMRDPT-1:0]               req_vld;
  logic [NUMRDPT*BITVBNK-1:0]       bank_sel;
  logic [NUMRDPT*NUMVBNK*WIDTH-1:0] bank_dout; // replica-major.

  dupmem_req_decode #(
    .WIDTH   (WIDTH),
    .NUMRDPT (NUMRDPT),
    .NUMADDR (NUMADDR),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW),
    .FLOPIN  (FLOPIN)
  ) u_decode (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .bw        (bw),
    .read      (read),
    .rd_adr    (rd_adr),
    .bank_we   (bank_we),
    .bank_wrow (bank_wrow),
    .bank_din  (bank_din),
    .bank_bw   (bank_bw),
    .bank_re   (bank_re),
    .bank_rrow (bank_rrow),
    .req_vld   (req_vld),
    .bank_sel  (bank_sel)
  );

  // every replica sees every write, but only its own port's reads.
  for (genvar r = 0; r < NUMRDPT; r++) begin : g_replica
    dupmem_replica #(
      .WIDTH      (WIDTH),
      .NUMVBNK    (NUMVBNK),
      .NUMVROW    (NUMVROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) u_replica (
      .clk       (clk),
      .bank_we   (bank_we),
      .bank_wrow (bank_wrow),
      .bank_din  (bank_din),
      .bank_bw   (bank_bw),
      .bank_re   (bank_re[r*NUMVBNK +: NUMVBNK]),
      .bank_rrow (bank_rrow[r*BITVROW +: BITVROW]),
      .bank_dout (bank_dout[r*NUMVBNK*WIDTH +: NUMVBNK*WIDTH])
    );
  end

  dupmem_read_return #(
    .WIDTH      (WIDTH),
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPOUT    (FLOPOUT)
  ) u_return (
    .clk       (clk),
    .rst       (rst),
    .req_vld   (req_vld),
    .bank_sel  (bank_sel),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

// File: verif/dupmem_prop_checker.sv
`timescale 1ns/1ps

module dupmem_prop_checker
  import dupmem_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMADDR    = DEF_NUMADDR,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  parameter int FLOPIN     = DEF_FLOPIN,
  parameter int FLOPOUT    = DEF_FLOPOUT
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               write,
  input  logic [$clog2(NUMADDR)-1:0]         wr_adr,
  input  logic [WIDTH-1:0]                   din,
  input  logic [WIDTH-1:0]                   bw,
  input  logic [NUMRDPT-1:0]                 read,
  input  logic [NUMRDPT*$clog2(NUMADDR)-1:0] rd_adr,
  input  logic [NUMRDPT-1:0]                 rd_vld,
  input  logic [NUMRDPT*WIDTH-1:0]           rd_dout,
  input  logic [$clog2(NUMADDR)-1:0]         sel_addr,
  input  logic [$clog2(WIDTH)-1:0]           sel_bit,
  output int                                 fail_cnt
);

  localparam int BITADDR = $clog2(NUMADDR);
  localparam int LAT     = FLOPIN + SRAM_DELAY + FLOPOUT;

  logic                     bit_val;    // last value written to the watched bit.
  logic                     bit_known;
  logic [BITADDR-1:0]       last_addr;
  logic [$clog2(WIDTH)-1:0] last_bit;
  logic [NUMRDPT-1:0]       trk_pipe [LAT+1]; // watched reads in flight.
  logic [NUMRDPT-1:0]       exp_pipe [LAT+1];

  initial begin
    fail_cnt  = 0;
    bit_known = 1'b0;
    last_addr = '0;
    last_bit  = '0;
    for (int i = 0; i <= LAT; i++) begin
      trk_pipe[i] = '0;
      exp_pipe[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (sel_addr != last_addr || sel_bit != last_bit) begin
      bit_known = 1'b0; // a new watch point starts unknown.
      last_addr = sel_addr;
      last_bit  = sel_bit;
      for (int i = 0; i <= LAT; i++) trk_pipe[i] = '0;
    end
    for (int i = LAT; i > 0; i--) begin
      trk_pipe[i] = rst ? '0 : trk_pipe[i-1];
      exp_pipe[i] = exp_pipe[i-1];
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      trk_pipe[0][p] = !rst && bit_known && read[p] &&
                       (rd_adr[p*BITADDR +: BITADDR] == sel_addr);
      exp_pipe[0][p] = bit_val; // sampled before this edge's write.
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      if (trk_pipe[LAT][p] && !rd_vld[p]) begin
        $display("checker: port %0d read of address 0x%0h came back without rd_vld",
                 p, sel_addr);
        fail_cnt++;
      end else if (trk_pipe[LAT][p] && rd_dout[p*WIDTH + sel_bit] !== exp_pipe[LAT][p]) begin
        $display("ERR rd_dout[%0d] bit %0d (bank %0d) got %h exp %h", p, sel_bit,
                 vbank_of(sel_addr, NUMVBNK), rd_dout[p*WIDTH + sel_bit], exp_pipe[LAT][p]);
        fail_cnt++;
      end
    end
    if (!rst && write && wr_adr == sel_addr && bw[sel_bit]) begin
      bit_val   = din[sel_bit];
      bit_known = 1'b1;
    end
  end

endmodule

// File: verif/tb_nr1w_dup_mem.sv
`timescale 1ns/1ps

module tb_nr1w_dup_mem
  import dupmem_pkg::*;
#(
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  parameter int FLOPIN     = DEF_FLOPIN,
  parameter int FLOPOUT    = DEF_FLOPOUT
);

  localparam int WIDTH   = DEF_WIDTH;
  localparam int NUMADDR = DEF_NUMADDR;
  localparam int BITADDR = $clog2(NUMADDR);
  localparam int LAT     = FLOPIN + SRAM_DELAY + FLOPOUT; // at least 1 here.
  localparam int CLK_NS  = 8;
  localparam int REGION  = 64;  // prefilled words for the random reads.
  localparam int NUM_RND = 200;
  localparam int PLAN_CYCLES = 2 + 10 + 2 * NUMVBNK + 3 + REGION + NUM_RND + 4
                             + 5 * (2 * LAT + 10);

  logic                       clk;
  logic                       rst;
  logic                       write;
  logic [BITADDR-1:0]         wr_adr;
  logic [WIDTH-1:0]           din;
  logic [WIDTH-1:0]           bw;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;
  logic [BITADDR-1:0]         sel_addr;
  logic [$clog2(WIDTH)-1:0]   sel_bit;
  int                         chk_fails;

  logic [WIDTH-1:0] ref_mem [NUMADDR];
  int               exp_port [$];
  int               exp_due [$];
  logic [WIDTH-1:0] exp_data [$];
  int               cyc;
  int               err_cnt;
  int               tests_run;
  int               tests_failed;
  logic [31:0]      lcg_state;

  nr1w_dup_mem #(
    .WIDTH (WIDTH), .NUMRDPT (NUMRDPT), .NUMADDR (NUMADDR), .NUMVBNK (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY), .FLOPIN (FLOPIN), .FLOPOUT (FLOPOUT)
  ) uut (.*);

  dupmem_prop_checker #(
    .WIDTH (WIDTH), .NUMRDPT (NUMRDPT), .NUMADDR (NUMADDR), .NUMVBNK (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY), .FLOPIN (FLOPIN), .FLOPOUT (FLOPOUT)
  ) u_checker (.*, .fail_cnt (chk_fails));

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(PLAN_CYCLES * 4 * CLK_NS);
    $display("timeout: run went past %0d cycles", PLAN_CYCLES * 4);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int total_errs();
    return err_cnt + chk_fails;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------------------
  // reference model and response monitor
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        if (read[p]) begin
          exp_port.push_back(p);
          exp_due.push_back(cyc + LAT - 1); // seen at the falling edge that follows.
          exp_data.push_back(ref_mem[rd_adr[p*BITADDR +: BITADDR]]);
        end
      end
      if (write) begin
        for (int i = 0; i < WIDTH; i++) begin
          if (bw[i]) ref_mem[wr_adr][i] = din[i];
        end
      end
    end
  end

  always @(negedge clk) begin : out_check
    logic [NUMRDPT-1:0] seen;
    seen = '0;
    while (!rst && exp_due.size() > 0 && exp_due[0] <= cyc) begin
      check($sformatf("rd_vld[%0d]", exp_port[0]), rd_vld[exp_port[0]], 1'b1);
      check($sformatf("rd_dout[%0d]", exp_port[0]),
            rd_dout[exp_port[0]*WIDTH +: WIDTH], exp_data[0]);
      seen[exp_port[0]] = 1'b1;
      void'(exp_port.pop_front());
      void'(exp_due.pop_front());
      void'(exp_data.pop_front());
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      if (!rst && !seen[p]) check($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
    end
  end

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------
  task automatic drive(input logic wr_en, input logic [BITADDR-1:0] wa,
                       input logic [WIDTH-1:0] wd, input logic [WIDTH-1:0] wm,
                       input logic [NUMRDPT-1:0] rd_en, input logic [NUMRDPT*BITADDR-1:0] ra);
    @(negedge clk);
    write  = wr_en;
    wr_adr = wa;
    din    = wd;
    bw     = wm;
    read   = rd_en;
    rd_adr = ra;
  endtask

  function automatic logic [NUMRDPT*BITADDR-1:0] all_ports(input logic [BITADDR-1:0] a);
    return {NUMRDPT{a}};
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    drive(1'b0, '0, '0, '0, '0, '0);
    while (exp_due.size() > 0 && n < LAT + 8) begin
      @(negedge clk);
      n++;
    end
    if (exp_due.size() > 0) begin
      $display("%0d expected reads never came back", exp_due.size());
      err_cnt++;
      exp_port.delete();
      exp_due.delete();
      exp_data.delete();
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (total_errs() != errs_before) begin
      tests_failed++;
      $display("test %-20s FAIL, %0d errors", name, total_errs() - errs_before);
    end else begin
      $display("test %-20s ok", name);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_idle_after_reset();
    int e0;
    e0 = total_errs();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check("rd_vld", rd_vld, '0);
    end
    end_test("idle_after_reset", e0);
  endtask

  task automatic test_bank_sweep();
    int e0;
    e0 = total_errs();
    sel_addr = BITADDR'(NUMVBNK * 5);
    sel_bit  = 3;
    for (int b = 0; b < NUMVBNK; b++) begin
      drive(1'b1, BITADDR'(NUMVBNK * (5 + b) + b), lcg_next(), '1, '0, '0);
    end
    for (int b = 0; b < NUMVBNK; b++) begin
      drive(1'b0, '0, '0, '0, '1, all_ports(BITADDR'(NUMVBNK * (5 + b) + b)));
    end
    wait_drain();
    end_test("bank_sweep", e0);
  endtask

  task automatic test_bit_mask();
    int e0;
    logic [WIDTH-1:0] old_word;
    logic [WIDTH-1:0] mask;
    e0 = total_errs();
    old_word = lcg_next();
    mask     = (lcg_next() | 32'h0000_0100) & ~32'h0001_0000; // bit 8 rewritten, bit 16 kept.
    sel_addr = BITADDR'(1234);
    sel_bit  = 8;
    drive(1'b1, sel_addr, old_word, '1, '0, '0);
    drive(1'b1, sel_addr, ~old_word, mask, '0, '0); // every bit differs from the old word.
    drive(1'b0, '0, '0, '0, '1, all_ports(sel_addr));
    wait_drain();
    end_test("bit_mask", e0);
  endtask

  task automatic test_random_reads();
    int e0;
    logic [NUMRDPT*BITADDR-1:0] ra;
    e0 = total_errs();
    sel_addr = BITADDR'(5);
    sel_bit  = 7;
    for (int i = 0; i < REGION; i++) drive(1'b1, BITADDR'(i), lcg_next(), '1, '0, '0);
    for (int k = 0; k < NUM_RND; k++) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        ra[p*BITADDR +: BITADDR] = BITADDR'((lcg_next() >> 16) % REGION);
      end
      drive(1'b0, '0, '0, '0, '1, ra);
    end
    wait_drain();
    end_test("random_reads", e0);
  endtask

  task automatic test_read_during_write();
    int e0;
    logic [WIDTH-1:0] old_word;
    e0 = total_errs();
    old_word = lcg_next();
    sel_addr = BITADDR'(NUMVBNK * 3 + NUMVBNK - 1);
    sel_bit  = 21;
    drive(1'b1, sel_addr, old_word, '1, '0, '0);
    drive(1'b1, sel_addr, ~old_word, '1, '1, all_ports(sel_addr)); // reads see old_word.
    drive(1'b0, '0, '0, '0, '1, all_ports(sel_addr));
    wait_drain();
    end_test("read_during_write", e0);
  endtask

  initial begin
    rst          = 1'b1;
    write        = 1'b0;
    wr_adr       = '0;
    din          = '0;
    bw           = '0;
    read         = '0;
    rd_adr       = '0;
    sel_addr     = '0;
    sel_bit      = '0;
    cyc          = 0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    lcg_state    = 32'd69;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_idle_after_reset();
    test_bank_sweep();
    test_bit_mask();
    test_random_reads();
    test_read_during_write();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs());
    if (total_errs() == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/dupmem_pkg.sv
logic/dupmem_req_decode.sv
logic/dupmem_replica.sv
logic/dupmem_read_return.sv
logic/nr1w_dup_mem.sv
verif/dupmem_prop_checker.sv
verif/tb_nr1w_dup_mem.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_nr1w_dup_mem
RTL_TOP    ?= nr1w_dup_mem
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= run.log
VFLAGS     ?= --timing

NUMRDPT    ?= 2
NUMVBNK    ?= 8
SRAM_DELAY ?= 2
FLOPIN     ?= 0
FLOPOUT    ?= 1

GFLAGS = -GNUMRDPT=$(NUMRDPT) -GNUMVBNK=$(NUMVBNK) -GSRAM_DELAY=$(SRAM_DELAY) \
         -GFLOPIN=$(FLOPIN) -GFLOPOUT=$(FLOPOUT)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP) $(GFLAGS)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP) $(GFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) $(GFLAGS) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "sim: pass" || (echo "sim: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
